// ==== hw/dmc_cfg.svh ====
/*
 * DMC configuration tag network constants
 * Frame field widths and the node number of every configuration client
 */
`ifndef DMC_CFG_SVH
`define DMC_CFG_SVH

// Frame layout, node field sent first
`define DMC_NODE_BITS      5
`define DMC_TAG_DATA_BITS  8
`define DMC_FRAME_BITS     (`DMC_NODE_BITS + `DMC_TAG_DATA_BITS)

// Controller parameter registers
`define DMC_NODE_TREFI0        0
`define DMC_NODE_TREFI1        1
`define DMC_NODE_TRFC_TMRD     2
`define DMC_NODE_TRP_TRC       3
`define DMC_NODE_TRRD_TRAS     4
`define DMC_NODE_TWR_TRCD      5
`define DMC_NODE_TRTP_TWTR     6
`define DMC_NODE_DQS_TCAS      7
`define DMC_NODE_ROW_COL       8
`define DMC_NODE_BANK          9
`define DMC_NODE_INIT0         10
`define DMC_NODE_INIT1         11

// System control bits
`define DMC_NODE_ASYNC_RESET   16
`define DMC_NODE_STALL         17
`define DMC_NODE_TEST_MODE     18

`endif

// ==== hw/dmc_tag_pkg.sv ====
/*
 * DMC tag network types
 * Tag lane, per-client tag line bundles, the payload views and the
 * controller parameter struct fed by the configuration generator
 */
`include "dmc_cfg.svh"

package dmc_tag_pkg;

    ////////////////////
    // Tag lanes

    typedef struct packed {
        logic valid;
        logic data;
    } dmc_tag_s;

    typedef struct packed {
        dmc_tag_s [1:0] trefi;
        dmc_tag_s       trfc_tmrd;
        dmc_tag_s       trp_trc;
        dmc_tag_s       trrd_tras;
        dmc_tag_s       twr_trcd;
        dmc_tag_s       trtp_twtr;
        dmc_tag_s       dqs_sel_cal_tcas;
        dmc_tag_s       row_width_col_width;
        dmc_tag_s       bank_pos_bank_width;
        dmc_tag_s [1:0] init_cycles;
    } dmc_cfg_tag_lines_s;

    typedef struct packed {
        dmc_tag_s async_reset;
        dmc_tag_s stall_transactions;
        dmc_tag_s test_mode;
    } dmc_sys_tag_lines_s;

    ////////////////////
    // Payload views

    typedef struct packed {
        logic [`DMC_TAG_DATA_BITS/2-1:0] hi;
        logic [`DMC_TAG_DATA_BITS/2-1:0] lo;
    } dmc_nibble_pair_s;

    // Whole byte for split wide registers, nibble pair for timing pairs
    typedef union packed {
        logic [`DMC_TAG_DATA_BITS-1:0] whole;
        dmc_nibble_pair_s              pair;
    } dmc_tag_payload_u;

    ////////////////////
    // Controller parameters

    typedef struct packed {
        logic [2*`DMC_TAG_DATA_BITS-1:0] trefi;
        logic [3:0]                      trfc;
        logic [3:0]                      tmrd;
        logic [3:0]                      trp;
        logic [3:0]                      trc;
        logic [3:0]                      trrd;
        logic [3:0]                      tras;
        logic [3:0]                      twr;
        logic [3:0]                      trcd;
        logic [3:0]                      trtp;
        logic [3:0]                      twtr;
        logic [3:0]                      tcas;
        logic [2:0]                      dqs_sel_cal;
        logic [3:0]                      row_width;
        logic [3:0]                      col_width;
        logic [3:0]                      bank_pos;
        logic [3:0]                      bank_width;
        logic [2*`DMC_TAG_DATA_BITS-1:0] init_cycles;
    } dmc_param_s;

endpackage

// ==== hw/dmc_tag_master.sv ====
/*
 * DMC tag master
 * Accepts one parallel write at a time and broadcasts it as a serial
 * frame on the tag lane, node first then payload, MSB first.
 * An idle cycle separates frames before ready returns.
 */
`timescale 1ns/1ps
`include "dmc_cfg.svh"

module dmc_tag_master
(
    input  logic                          dfi_clk_1x_i,
    input  logic                          rst_i,
    input  logic                          wr_v_i,
    input  logic [`DMC_NODE_BITS-1:0]     wr_node_i,
    input  logic [`DMC_TAG_DATA_BITS-1:0] wr_data_i,
    output logic                          ready_o,
    output dmc_tag_pkg::dmc_tag_s         tag_o
);

    localparam int unsigned CNT_W = $clog2(`DMC_FRAME_BITS + 2);
    localparam logic [CNT_W-1:0] FRAME_LEN = CNT_W'(`DMC_FRAME_BITS);
    // Last count of the busy period, covers the idle gap
    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(`DMC_FRAME_BITS + 1);

    logic [`DMC_FRAME_BITS-1:0] shift_r;
    logic [CNT_W-1:0]           cnt_r;
    logic                       tag_v_r;
    logic                       tag_d_r;
    logic                       accept_w;

    assign accept_w = wr_v_i && ready_o;

    ////////////////////
    // Control

    always_ff @(posedge dfi_clk_1x_i)
    begin
        if (rst_i)
        begin
            ready_o <= 1'b1;
            cnt_r   <= '0;
            tag_v_r <= 1'b0;
        end
        else if (ready_o)
        begin
            tag_v_r <= 1'b0;
            if (accept_w)
            begin
                ready_o <= 1'b0;
                cnt_r   <= '0;
            end
        end
        else
        begin
            tag_v_r <= (cnt_r < FRAME_LEN);
            cnt_r   <= cnt_r + 1'b1;
            if (cnt_r == LAST_CNT)
                ready_o <= 1'b1;
        end
    end

    ////////////////////
    // Serializer

    always_ff @(posedge dfi_clk_1x_i)
    begin
        if (accept_w)
        begin
            shift_r <= {wr_node_i, wr_data_i};
        end
        else if (!ready_o)
        begin
            tag_d_r <= shift_r[`DMC_FRAME_BITS-1];
            shift_r <= {shift_r[`DMC_FRAME_BITS-2:0], 1'b0};
        end
    end

    assign tag_o.valid = tag_v_r;
    assign tag_o.data  = tag_d_r;

endmodule

// ==== hw/dmc_tag_client.sv ====
/*
 * DMC tag client
 * Collects one serial frame from the tag lane and keeps the low
 * WIDTH payload bits when the node field matches NODE_ID.
 * Partial frames are dropped.
 */
`timescale 1ns/1ps
`include "dmc_cfg.svh"

module dmc_tag_client
#(
    parameter int unsigned NODE_ID = 0,
    parameter int unsigned WIDTH   = `DMC_TAG_DATA_BITS
)
(
    input  logic                  dfi_clk_1x_i,
    input  logic                  rst_i,
    input  dmc_tag_pkg::dmc_tag_s tag_i,
    output logic                  recv_new_r_o,
    output logic [WIDTH-1:0]      recv_data_r_o
);

    localparam int unsigned CNT_W = $clog2(`DMC_FRAME_BITS + 1);
    localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(`DMC_FRAME_BITS - 1);
    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(`DMC_FRAME_BITS);
    localparam logic [`DMC_NODE_BITS-1:0] MY_NODE = `DMC_NODE_BITS'(NODE_ID);

    logic [`DMC_FRAME_BITS-2:0] shift_r;
    logic [CNT_W-1:0]           cnt_r;
    logic [`DMC_FRAME_BITS-1:0] frame_w;
    logic                       frame_done_w;
    logic                       node_hit_w;

    // Current lane bit completes the frame on the last count
    assign frame_w      = {shift_r, tag_i.data};
    assign frame_done_w = tag_i.valid && (cnt_r == LAST_BIT);
    assign node_hit_w   = (frame_w[`DMC_FRAME_BITS-1 -: `DMC_NODE_BITS] == MY_NODE);

    ////////////////////
    // Bit counter

    always_ff @(posedge dfi_clk_1x_i)
    begin
        if (rst_i)
            cnt_r <= '0;
        else if (!tag_i.valid)
            cnt_r <= '0;
        else if (cnt_r != FULL_CNT)
            cnt_r <= cnt_r + 1'b1;
    end

    always_ff @(posedge dfi_clk_1x_i)
    begin
        if (tag_i.valid)
            shift_r <= frame_w[`DMC_FRAME_BITS-2:0];
    end

    ////////////////////
    // Received value

    always_ff @(posedge dfi_clk_1x_i)
    begin
        if (rst_i)
        begin
            recv_new_r_o  <= 1'b0;
            recv_data_r_o <= '0;
        end
        else
        begin
            recv_new_r_o <= frame_done_w && node_hit_w;
            if (frame_done_w && node_hit_w)
                recv_data_r_o <= frame_w[WIDTH-1:0];
        end
    end

endmodule

// ==== hw/dmc_sys_cfg_gen.sv ====
/*
 * DMC system configuration generator
 * One tag client per configuration register. Client values are mapped
 * into the controller parameter struct and three system control bits.
 */
`timescale 1ns/1ps
`include "dmc_cfg.svh"

module dmc_sys_cfg_gen
(
    input  logic                            dfi_clk_1x_i,
    input  logic                            rst_i,
    input  dmc_tag_pkg::dmc_cfg_tag_lines_s cfg_tag_lines_i,
    input  dmc_tag_pkg::dmc_sys_tag_lines_s sys_tag_lines_i,
    output dmc_tag_pkg::dmc_param_s         dmc_p_o,
    output logic                            async_reset_o,
    output logic                            stall_transactions_o,
    output logic                            test_mode_o
);

    import dmc_tag_pkg::*;

    localparam int unsigned BYTE_W = `DMC_TAG_DATA_BITS;

    // Nibble pair registers, first named field in hi
    localparam int unsigned PAIR_NODE [7] = '{
        `DMC_NODE_TRFC_TMRD,
        `DMC_NODE_TRP_TRC,
        `DMC_NODE_TRRD_TRAS,
        `DMC_NODE_TWR_TRCD,
        `DMC_NODE_TRTP_TWTR,
        `DMC_NODE_ROW_COL,
        `DMC_NODE_BANK
    };
    localparam int unsigned SYS_NODE [3] = '{
        `DMC_NODE_ASYNC_RESET,
        `DMC_NODE_STALL,
        `DMC_NODE_TEST_MODE
    };

    dmc_tag_payload_u trefi_val_w [2];
    dmc_tag_payload_u init_val_w [2];
    dmc_tag_s         pair_tag_w [7];
    dmc_tag_payload_u pair_val_w [7];
    logic [6:0]       dqs_tcas_w;
    dmc_tag_s         sys_tag_w [3];
    logic             sys_val_w [3];

    assign pair_tag_w = '{
        cfg_tag_lines_i.trfc_tmrd,
        cfg_tag_lines_i.trp_trc,
        cfg_tag_lines_i.trrd_tras,
        cfg_tag_lines_i.twr_trcd,
        cfg_tag_lines_i.trtp_twtr,
        cfg_tag_lines_i.row_width_col_width,
        cfg_tag_lines_i.bank_pos_bank_width
    };
    assign sys_tag_w = '{
        sys_tag_lines_i.async_reset,
        sys_tag_lines_i.stall_transactions,
        sys_tag_lines_i.test_mode
    };

    ////////////////////
    // Split 16-bit registers, index 1 is the upper byte

    for (genvar i = 0; i < 2; i++)
    begin : g_wide
        dmc_tag_client #(.NODE_ID(`DMC_NODE_TREFI0 + i), .WIDTH(BYTE_W)) u_trefi
        (
            .dfi_clk_1x_i  (dfi_clk_1x_i),
            .rst_i         (rst_i),
            .tag_i         (cfg_tag_lines_i.trefi[i]),
            .recv_new_r_o  (),
            .recv_data_r_o (trefi_val_w[i])
        );

        dmc_tag_client #(.NODE_ID(`DMC_NODE_INIT0 + i), .WIDTH(BYTE_W)) u_init
        (
            .dfi_clk_1x_i  (dfi_clk_1x_i),
            .rst_i         (rst_i),
            .tag_i         (cfg_tag_lines_i.init_cycles[i]),
            .recv_new_r_o  (),
            .recv_data_r_o (init_val_w[i])
        );

        assign dmc_p_o.trefi[i*BYTE_W +: BYTE_W]       = trefi_val_w[i].whole;
        assign dmc_p_o.init_cycles[i*BYTE_W +: BYTE_W] = init_val_w[i].whole;
    end

    ////////////////////
    // Timing pairs

    for (genvar i = 0; i < 7; i++)
    begin : g_pair
        dmc_tag_client #(.NODE_ID(PAIR_NODE[i]), .WIDTH(BYTE_W)) u_client
        (
            .dfi_clk_1x_i  (dfi_clk_1x_i),
            .rst_i         (rst_i),
            .tag_i         (pair_tag_w[i]),
            .recv_new_r_o  (),
            .recv_data_r_o (pair_val_w[i])
        );
    end

    assign dmc_p_o.trfc       = pair_val_w[0].pair.hi;
    assign dmc_p_o.tmrd       = pair_val_w[0].pair.lo;
    assign dmc_p_o.trp        = pair_val_w[1].pair.hi;
    assign dmc_p_o.trc        = pair_val_w[1].pair.lo;
    assign dmc_p_o.trrd       = pair_val_w[2].pair.hi;
    assign dmc_p_o.tras       = pair_val_w[2].pair.lo;
    assign dmc_p_o.twr        = pair_val_w[3].pair.hi;
    assign dmc_p_o.trcd       = pair_val_w[3].pair.lo;
    assign dmc_p_o.trtp       = pair_val_w[4].pair.hi;
    assign dmc_p_o.twtr       = pair_val_w[4].pair.lo;
    assign dmc_p_o.row_width  = pair_val_w[5].pair.hi;
    assign dmc_p_o.col_width  = pair_val_w[5].pair.lo;
    assign dmc_p_o.bank_pos   = pair_val_w[6].pair.hi;
    assign dmc_p_o.bank_width = pair_val_w[6].pair.lo;

    // DQS select is 3 bits, top payload bit not kept
    dmc_tag_client #(.NODE_ID(`DMC_NODE_DQS_TCAS), .WIDTH(7)) u_dqs_tcas
    (
        .dfi_clk_1x_i  (dfi_clk_1x_i),
        .rst_i         (rst_i),
        .tag_i         (cfg_tag_lines_i.dqs_sel_cal_tcas),
        .recv_new_r_o  (),
        .recv_data_r_o (dqs_tcas_w)
    );

    assign dmc_p_o.dqs_sel_cal = dqs_tcas_w[6:4];
    assign dmc_p_o.tcas        = dqs_tcas_w[3:0];

    ////////////////////
    // System control bits

    for (genvar i = 0; i < 3; i++)
    begin : g_sys
        dmc_tag_client #(.NODE_ID(SYS_NODE[i]), .WIDTH(1)) u_client
        (
            .dfi_clk_1x_i  (dfi_clk_1x_i),
            .rst_i         (rst_i),
            .tag_i         (sys_tag_w[i]),
            .recv_new_r_o  (),
            .recv_data_r_o (sys_val_w[i])
        );
    end

    assign async_reset_o        = sys_val_w[0];
    assign stall_transactions_o = sys_val_w[1];
    assign test_mode_o          = sys_val_w[2];

endmodule

// ==== hw/dmc_cfg_top.sv ====
/*
 * DMC configuration path top
 * Tag master driving a single lane, broadcast to every client
 * of the configuration generator
 */
`timescale 1ns/1ps
`include "dmc_cfg.svh"

module dmc_cfg_top
(
    input  logic                          dfi_clk_1x_i,
    input  logic                          rst_i,
    input  logic                          wr_v_i,
    input  logic [`DMC_NODE_BITS-1:0]     wr_node_i,
    input  logic [`DMC_TAG_DATA_BITS-1:0] wr_data_i,
    output logic                          ready_o,
    output dmc_tag_pkg::dmc_param_s       dmc_p_o,
    output logic                          async_reset_o,
    output logic                          stall_transactions_o,
    output logic                          test_mode_o
);

    import dmc_tag_pkg::*;

    dmc_tag_s           tag_w;
    dmc_cfg_tag_lines_s cfg_lines_w;
    dmc_sys_tag_lines_s sys_lines_w;

    dmc_tag_master u_master
    (
        .dfi_clk_1x_i (dfi_clk_1x_i),
        .rst_i        (rst_i),
        .wr_v_i       (wr_v_i),
        .wr_node_i    (wr_node_i),
        .wr_data_i    (wr_data_i),
        .ready_o      (ready_o),
        .tag_o        (tag_w)
    );

    // Broadcast, clients filter on node number
    assign cfg_lines_w.trefi               = {2{tag_w}};
    assign cfg_lines_w.trfc_tmrd           = tag_w;
    assign cfg_lines_w.trp_trc             = tag_w;
    assign cfg_lines_w.trrd_tras           = tag_w;
    assign cfg_lines_w.twr_trcd            = tag_w;
    assign cfg_lines_w.trtp_twtr           = tag_w;
    assign cfg_lines_w.dqs_sel_cal_tcas    = tag_w;
    assign cfg_lines_w.row_width_col_width = tag_w;
    assign cfg_lines_w.bank_pos_bank_width = tag_w;
    assign cfg_lines_w.init_cycles         = {2{tag_w}};

    assign sys_lines_w.async_reset        = tag_w;
    assign sys_lines_w.stall_transactions = tag_w;
    assign sys_lines_w.test_mode          = tag_w;

    dmc_sys_cfg_gen u_cfg_gen
    (
        .dfi_clk_1x_i         (dfi_clk_1x_i),
        .rst_i                (rst_i),
        .cfg_tag_lines_i      (cfg_lines_w),
        .sys_tag_lines_i      (sys_lines_w),
        .dmc_p_o              (dmc_p_o),
        .async_reset_o        (async_reset_o),
        .stall_transactions_o (stall_transactions_o),
        .test_mode_o          (test_mode_o)
    );

endmodule

// ==== dv/dmc_cfg_checker.sv ====
/*
 * DMC tag checker
 * Frame length on the tag lane and ready timing of the tag master
 */
`timescale 1ns/1ps
`include "dmc_cfg.svh"

module dmc_cfg_checker
(
    input logic                  clk_i,
    input logic                  rst_i,
    input logic                  wr_v_i,
    input logic                  ready_i,
    input dmc_tag_pkg::dmc_tag_s tag_i
);

    logic [4:0] run_cnt_r;
    logic       len_fail    = 1'b0;
    logic       ready_fail  = 1'b0;
    logic       accept_fail = 1'b0;
    logic       fail_seen;

    assign fail_seen = len_fail || ready_fail || accept_fail;

    // Length of the current valid run
    always_ff @(posedge clk_i)
    begin
        if (rst_i || !tag_i.valid)
            run_cnt_r <= '0;
        else if (run_cnt_r != 5'h1f)
            run_cnt_r <= run_cnt_r + 1'b1;
    end

    ////////////////////
    // Properties

    frame_len_a: assert property (@(posedge clk_i) disable iff (rst_i)
        $fell(tag_i.valid) |-> (run_cnt_r == 5'(`DMC_FRAME_BITS)))
    else
    begin
        len_fail = 1'b1;
        $error("tag valid run of %0d cycles", run_cnt_r);
    end

    busy_ready_a: assert property (@(posedge clk_i) disable iff (rst_i)
        tag_i.valid |-> !ready_i)
    else
    begin
        ready_fail = 1'b1;
        $error("ready high during a tag frame");
    end

    accept_a: assert property (@(posedge clk_i) disable iff (rst_i)
        (wr_v_i && ready_i) |=> !ready_i)
    else
    begin
        accept_fail = 1'b1;
        $error("ready still high after an accepted write");
    end

endmodule

bind dmc_cfg_top dmc_cfg_checker u_checker
(
    .clk_i   (dfi_clk_1x_i),
    .rst_i   (rst_i),
    .wr_v_i  (wr_v_i),
    .ready_i (ready_o),
    .tag_i   (tag_w)
);

// ==== dv/dmc_cfg_tb.sv ====
/*
 * DMC configuration path testbench
 * Table of writes sent through the tag master, each checked against
 * a model of the register mapping once ready returns
 */
`timescale 1ns/1ps
`include "dmc_cfg.svh"

module dmc_cfg_tb;

    import dmc_tag_pkg::*;

    localparam int unsigned RESET_CYCLES    = 8;
    localparam int unsigned N_DIRECTED      = 22;
    localparam int unsigned N_RANDOM        = 24;
    localparam int unsigned N_ENTRIES       = N_DIRECTED + N_RANDOM;
    localparam int unsigned MARGIN_CYCLES   = 400;
    localparam int unsigned WATCHDOG_CYCLES = N_ENTRIES * 16 + RESET_CYCLES + MARGIN_CYCLES;
    localparam int unsigned UNUSED_NODE     = 25;
    localparam logic [4:0]  HELD_NODE       = 5'(`DMC_NODE_TWR_TRCD);

    typedef struct packed {
        dmc_param_s p;
        logic       async_reset;
        logic       stall;
        logic       test_mode;
    } cfg_state_s;

    typedef struct packed {
        logic [`DMC_NODE_BITS-1:0]     node;
        logic [`DMC_TAG_DATA_BITS-1:0] data;
        cfg_state_s                    expected;
    } write_entry_s;

    localparam int CHK_W = $bits(cfg_state_s);

    // Every config node, bit 7 on dqs/tcas, system bits, unused node, rewrites
    localparam int unsigned DIR_NODE [N_DIRECTED] = '{
        `DMC_NODE_TREFI0, `DMC_NODE_TREFI1, `DMC_NODE_TRFC_TMRD, `DMC_NODE_TRP_TRC,
        `DMC_NODE_TRRD_TRAS, `DMC_NODE_TWR_TRCD, `DMC_NODE_TRTP_TWTR, `DMC_NODE_DQS_TCAS,
        `DMC_NODE_ROW_COL, `DMC_NODE_BANK, `DMC_NODE_INIT0, `DMC_NODE_INIT1,
        `DMC_NODE_DQS_TCAS, `DMC_NODE_ASYNC_RESET, `DMC_NODE_STALL, `DMC_NODE_TEST_MODE,
        UNUSED_NODE, `DMC_NODE_ASYNC_RESET, `DMC_NODE_TEST_MODE, `DMC_NODE_TRFC_TMRD,
        `DMC_NODE_TREFI1, `DMC_NODE_STALL
    };
    localparam logic [7:0] DIR_DATA [N_DIRECTED] = '{
        8'h34, 8'h12, 8'ha5, 8'h3c, 8'h96, 8'h7e, 8'h5b, 8'hd9, 8'he8, 8'h43, 8'h21,
        8'h0f, 8'h80, 8'h01, 8'h01, 8'h03, 8'hff, 8'hfe, 8'h00, 8'h1f, 8'hc0, 8'h02
    };

    logic         clk;
    logic         rst;
    logic         wr_v;
    logic [4:0]   wr_node;
    logic [7:0]   wr_data;
    logic         ready;
    dmc_param_s   dmc_p;
    logic         async_reset;
    logic         stall;
    logic         test_mode;
    write_entry_s table_q [N_ENTRIES];

    dmc_cfg_top UUT
    (
        .dfi_clk_1x_i         (clk),
        .rst_i                (rst),
        .wr_v_i               (wr_v),
        .wr_node_i            (wr_node),
        .wr_data_i            (wr_data),
        .ready_o              (ready),
        .dmc_p_o              (dmc_p),
        .async_reset_o        (async_reset),
        .stall_transactions_o (stall),
        .test_mode_o          (test_mode)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    ////////////////////
    // Model and helpers

    function automatic cfg_state_s apply_write(input cfg_state_s s, input logic [4:0] node,
                                               input logic [7:0] data);
        cfg_state_s n;
        n = s;
        case (int'(node))
            `DMC_NODE_TREFI0:      n.p.trefi[7:0] = data;
            `DMC_NODE_TREFI1:      n.p.trefi[15:8] = data;
            `DMC_NODE_TRFC_TMRD:   {n.p.trfc, n.p.tmrd} = data;
            `DMC_NODE_TRP_TRC:     {n.p.trp, n.p.trc} = data;
            `DMC_NODE_TRRD_TRAS:   {n.p.trrd, n.p.tras} = data;
            `DMC_NODE_TWR_TRCD:    {n.p.twr, n.p.trcd} = data;
            `DMC_NODE_TRTP_TWTR:   {n.p.trtp, n.p.twtr} = data;
            `DMC_NODE_DQS_TCAS:    {n.p.dqs_sel_cal, n.p.tcas} = data[6:0];
            `DMC_NODE_ROW_COL:     {n.p.row_width, n.p.col_width} = data;
            `DMC_NODE_BANK:        {n.p.bank_pos, n.p.bank_width} = data;
            `DMC_NODE_INIT0:       n.p.init_cycles[7:0] = data;
            `DMC_NODE_INIT1:       n.p.init_cycles[15:8] = data;
            `DMC_NODE_ASYNC_RESET: n.async_reset = data[0];
            `DMC_NODE_STALL:       n.stall = data[0];
            `DMC_NODE_TEST_MODE:   n.test_mode = data[0];
            default:               ;
        endcase
        return n;
    endfunction

    function automatic cfg_state_s current_state();
        return cfg_state_s'({dmc_p, async_reset, stall, test_mode});
    endfunction

    task automatic check_value(input logic [CHK_W-1:0] actual, input logic [CHK_W-1:0] expected,
                               input string what);
        if (actual !== expected)
        begin
            $display("FAILED at time %0t: %s, got %h, expected %h", $time, what, actual, expected);
            $display("Simulation failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic build_table();
        cfg_state_s  model;
        int unsigned pick;
        model = '0;
        for (int i = 0; i < N_ENTRIES; i++)
        begin
            if (i < N_DIRECTED)
            begin
                table_q[i].node = 5'(DIR_NODE[i]);
                table_q[i].data = DIR_DATA[i];
            end
            else
            begin
                // Twelve config nodes, then the system nodes from 16
                pick = $urandom_range(14, 0);
                table_q[i].node = 5'((pick < 12) ? pick : pick + 4);
                table_q[i].data = 8'($urandom);
            end
            model = apply_write(model, table_q[i].node, table_q[i].data);
            table_q[i].expected = model;
        end
    endtask

    task automatic send_write(input logic [4:0] node, input logic [7:0] data);
        @(posedge clk);
        wr_v    <= 1'b1;
        wr_node <= node;
        wr_data <= data;
        @(posedge clk);
        wr_v    <= 1'b0;
    endtask

    task automatic wait_ready();
        @(negedge clk);
        while (!ready)
            @(negedge clk);
    endtask

    // Second write held on the strobe while the first frame is sent
    task automatic held_write(input cfg_state_s start);
        cfg_state_s model;
        model = apply_write(start, HELD_NODE, 8'h12);
        @(posedge clk);
        wr_v    <= 1'b1;
        wr_node <= HELD_NODE;
        wr_data <= 8'h12;
        @(posedge clk);
        wr_data <= 8'h9f;
        wait_ready();
        check_value(current_state(), model, "first write ahead of held write");
        @(posedge clk);
        wr_v <= 1'b0;
        @(negedge clk);
        check_value(CHK_W'(ready), '0, "held write not taken after ready");
        wait_ready();
        model = apply_write(model, HELD_NODE, 8'h9f);
        check_value(current_state(), model, "held write");
        repeat (3)
        begin
            @(negedge clk);
            check_value(CHK_W'(ready), CHK_W'(1'b1), "held write taken twice");
        end
    endtask

    ////////////////////
    // Main sequence

    initial
    begin
        void'($urandom(82119));
        rst     = 1'b1;
        wr_v    = 1'b0;
        wr_node = '0;
        wr_data = '0;
        build_table();
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value(current_state(), '0, "outputs after reset");
        check_value(CHK_W'(ready), CHK_W'(1'b1), "ready after reset");
        for (int i = 0; i < N_ENTRIES; i++)
        begin
            wait_ready();
            send_write(table_q[i].node, table_q[i].data);
            wait_ready();
            check_value(current_state(), table_q[i].expected,
                        $sformatf("entry %0d to node %0d", i, table_q[i].node));
        end
        held_write(table_q[N_ENTRIES-1].expected);
        if (UUT.u_checker.fail_seen)
        begin
            $display("Tag checker reported a protocol error");
            $display("Simulation failed");
            $fatal(1, "assertion failure");
        end
        else
        begin
            $display("Simulation passed");
            $finish;
        end
    end

    always @(negedge clk)
    begin
        if (UUT.u_checker.fail_seen)
        begin
            $display("Tag checker assertion failed at time %0t", $time);
            $display("Simulation failed");
            $fatal(1, "assertion failure");
        end
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles, the writes did not complete", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== compile.f ====
+incdir+hw
hw/dmc_tag_pkg.sv
hw/dmc_tag_master.sv
hw/dmc_tag_client.sv
hw/dmc_sys_cfg_gen.sv
hw/dmc_cfg_top.sv
dv/dmc_cfg_checker.sv
dv/dmc_cfg_tb.sv

// ==== Makefile ====
# Verilator build and run for the DMC configuration path

VERILATOR ?= verilator
TOP       ?= dmc_cfg_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard hw/*.svh)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source, header or the file list changes
$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	$(BIN) 2>&1 | tee $(LOG)
	@grep -q "^Simulation passed" $(LOG) || (echo "Run failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
